// ==== Makefile ====
# Verilator build and run for the game ROM memory testbench

VERILATOR ?= verilator
TOP       ?= tb_game_mem
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert --timing -Wno-fatal
RUN_ARGS  ?= +verilator+error+limit+1000

BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BIN)
	$(BIN) $(RUN_ARGS) | tee $(LOG)
	@grep -q "=== PASS ===" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== logic/rom_dwnld.sv ====
//////////////////////////////////////////////////
// Host byte stream to SDRAM writes. Bytes from
// PROM_START up are dropped. Only one write is
// pending, the host waits for it to finish.
//////////////////////////////////////////////////
`default_nettype none

module rom_dwnld (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   downloading,
    input  logic                   ioctl_wr,
    input  logic                   sdram_ack,
    input  logic [24:0]            ioctl_addr,
    input  rom_map_pkg::byte_t     ioctl_dout,
    output sdram_pkg::sdram_addr_t prog_addr,
    output rom_map_pkg::byte_t     prog_data,
    output sdram_pkg::prog_mask_t  prog_mask,
    output logic                   prog_we
);
    import sdram_pkg::*;
    import rom_map_pkg::*;

    sdram_addr_t waddr;
    sdram_addr_t mem_addr;
    logic        in_scr;
    logic        in_obj;
    logic        in_prom;
    logic        accept;

    assign waddr = ioctl_addr[22:1];

    assign in_scr  = (ioctl_addr >= 25'(SCR_START)) && (ioctl_addr < 25'(OBJ_START));
    assign in_obj  = (ioctl_addr >= 25'(OBJ_START)) && (ioctl_addr < 25'(PROM_START));
    assign in_prom = ioctl_addr >= 25'(PROM_START);

    // Graphics bit shuffle so a tile row is one fetch
    always_comb begin
        mem_addr = waddr;
        if (in_scr) begin
            mem_addr[3:0] = {waddr[2:0], ~waddr[3]};
        end
        if (in_obj) begin
            mem_addr[0]   = ~waddr[3];
            mem_addr[1]   = ~waddr[4];
            mem_addr[5:2] = {waddr[5], waddr[2:0]};
        end
    end

    assign accept = downloading && ioctl_wr && !in_prom && !prog_we;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            prog_we <= 1'b0;
        end else if (accept) begin
            prog_we <= 1'b1;
        end else if (sdram_ack) begin
            prog_we <= 1'b0;
        end
    end

    // Held stable while prog_we is up
    always_ff @(posedge clk) begin
        if (accept) begin
            prog_addr <= mem_addr;
            prog_data <= ioctl_dout;
            // Even byte to the upper half
            prog_mask <= ioctl_addr[0] ? 2'b10 : 2'b01;
        end
    end

endmodule

`default_nettype wire

// ==== logic/rom_game_mem.sv ====
//////////////////////////////////////////////////
// ROM memory side of the game core. Clients must
// hold cs and addr until ok. Writes and reads
// share one SDRAM port, downloading selects.
//////////////////////////////////////////////////
`default_nettype none

module rom_game_mem (
    input  logic                   clk,
    input  logic                   rst_n,
    // Download
    input  logic                   downloading,
    input  logic                   ioctl_wr,
    input  logic [24:0]            ioctl_addr,
    input  rom_map_pkg::byte_t     ioctl_dout,
    output sdram_pkg::sdram_addr_t prog_addr,
    output rom_map_pkg::byte_t     prog_data,
    output sdram_pkg::prog_mask_t  prog_mask,
    output logic                   prog_we,
    // SDRAM
    input  logic                   sdram_ack,
    input  logic                   data_dst,
    input  logic                   data_rdy,
    input  sdram_pkg::sdram_word_t data_read,
    output logic                   sdram_req,
    output sdram_pkg::sdram_addr_t sdram_addr,
    // ROM clients
    input  logic                   main_cs,
    input  rom_map_pkg::main_addr_t main_addr,
    output rom_map_pkg::byte_t     main_data,
    output logic                   main_ok,
    input  logic                   snd_cs,
    input  rom_map_pkg::snd_addr_t snd_addr,
    output rom_map_pkg::byte_t     snd_data,
    output logic                   snd_ok,
    input  logic                   scr_cs,
    input  rom_map_pkg::scr_addr_t scr_addr,
    output rom_map_pkg::gfx_word_t scr_data,
    output logic                   scr_ok,
    input  logic                   obj_cs,
    input  rom_map_pkg::obj_addr_t obj_addr,
    output rom_map_pkg::gfx_word_t obj_data,
    output logic                   obj_ok
);
    import sdram_pkg::*;
    import rom_map_pkg::*;

    sdram_req_t slot_req [N_SLOTS];
    sdram_rsp_t slot_rsp [N_SLOTS];

    rom_dwnld u_dwnld (
        .clk         ( clk         ),
        .rst_n       ( rst_n       ),
        .downloading ( downloading ),
        .ioctl_wr    ( ioctl_wr    ),
        .sdram_ack   ( sdram_ack   ),
        .ioctl_addr  ( ioctl_addr  ),
        .ioctl_dout  ( ioctl_dout  ),
        .prog_addr   ( prog_addr   ),
        .prog_data   ( prog_data   ),
        .prog_mask   ( prog_mask   ),
        .prog_we     ( prog_we     )
    );

    rom_slot #(.AW($bits(main_addr_t)), .DW(8), .OFFSET(22'd0)) u_main (
        .clk     ( clk                 ),
        .rst_n   ( rst_n               ),
        .cs      ( main_cs             ),
        .addr    ( main_addr           ),
        .mem_rsp ( slot_rsp[SLOT_MAIN] ),
        .dout    ( main_data           ),
        .ok      ( main_ok             ),
        .mem_req ( slot_req[SLOT_MAIN] )
    );

    rom_slot #(.AW($bits(snd_addr_t)), .DW(8), .OFFSET(SND_START >> 1)) u_snd (
        .clk     ( clk                ),
        .rst_n   ( rst_n              ),
        .cs      ( snd_cs             ),
        .addr    ( snd_addr           ),
        .mem_rsp ( slot_rsp[SLOT_SND] ),
        .dout    ( snd_data           ),
        .ok      ( snd_ok             ),
        .mem_req ( slot_req[SLOT_SND] )
    );

    rom_slot #(.AW($bits(scr_addr_t)), .DW(32), .OFFSET(SCR_START >> 1)) u_scr (
        .clk     ( clk                ),
        .rst_n   ( rst_n              ),
        .cs      ( scr_cs             ),
        .addr    ( scr_addr           ),
        .mem_rsp ( slot_rsp[SLOT_SCR] ),
        .dout    ( scr_data           ),
        .ok      ( scr_ok             ),
        .mem_req ( slot_req[SLOT_SCR] )
    );

    rom_slot #(.AW($bits(obj_addr_t)), .DW(32), .OFFSET(OBJ_START >> 1)) u_obj (
        .clk     ( clk                ),
        .rst_n   ( rst_n              ),
        .cs      ( obj_cs             ),
        .addr    ( obj_addr           ),
        .mem_rsp ( slot_rsp[SLOT_OBJ] ),
        .dout    ( obj_data           ),
        .ok      ( obj_ok             ),
        .mem_req ( slot_req[SLOT_OBJ] )
    );

    slot_arbiter u_arb (
        .clk         ( clk         ),
        .rst_n       ( rst_n       ),
        .downloading ( downloading ),
        .slot_req    ( slot_req    ),
        .sdram_ack   ( sdram_ack   ),
        .data_dst    ( data_dst    ),
        .data_rdy    ( data_rdy    ),
        .data_read   ( data_read   ),
        .slot_rsp    ( slot_rsp    ),
        .sdram_req   ( sdram_req   ),
        .sdram_addr  ( sdram_addr  )
    );

endmodule

`default_nettype wire

// ==== logic/rom_map_pkg.sv ====
//////////////////////////////////////////////////
// Game ROM layout inside the SDRAM. Offsets are
// byte offsets and must keep the low six word
// address bits clear for the graphics scrambling.
// Main code always starts at byte 0.
//////////////////////////////////////////////////
`default_nettype none

package rom_map_pkg;

    // Region start, in bytes
    localparam logic [21:0] SND_START  = 22'h01_0000;
    localparam logic [21:0] SCR_START  = 22'h01_4000;
    localparam logic [21:0] OBJ_START  = 22'h01_C000;
    localparam logic [21:0] PROM_START = 22'h02_C000;

    localparam int N_SLOTS = 4;

    // Lower index wins arbitration
    localparam int SLOT_MAIN = 0;
    localparam int SLOT_SND  = 1;
    localparam int SLOT_SCR  = 2;
    localparam int SLOT_OBJ  = 3;

    // Client address widths
    typedef logic [15:0] main_addr_t;
    typedef logic [13:0] snd_addr_t;
    typedef logic [12:0] scr_addr_t;
    typedef logic [13:0] obj_addr_t;

    typedef logic [7:0]  byte_t;
    typedef logic [31:0] gfx_word_t;

    typedef enum logic [1:0] {
        idle,
        wait_ack,
        wait_data
    } slot_state_t;

endpackage

`default_nettype wire

// ==== logic/rom_slot.sv ====
//////////////////////////////////////////////////
// Read only cache of one SDRAM word per client.
// DW is 8 or 32. An 8-bit client addresses bytes,
// a 32-bit client addresses 32-bit words.
// OFFSET is the region start in 16-bit words.
//////////////////////////////////////////////////
`default_nettype none

module rom_slot #(
    parameter int                    AW     = 16,
    parameter int                    DW     = 8,
    parameter sdram_pkg::sdram_addr_t OFFSET = '0
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  cs,
    input  logic [AW-1:0]         addr,
    input  sdram_pkg::sdram_rsp_t mem_rsp,
    output logic [DW-1:0]         dout,
    output logic                  ok,
    output sdram_pkg::sdram_req_t mem_req
);
    import sdram_pkg::*;
    import rom_map_pkg::*;

    // Words per fetch and tag width
    localparam int NW  = (DW == 32) ? 2 : 1;
    localparam int TW  = (DW == 32) ? AW : AW - 1;
    localparam int WSH = (DW == 32) ? 1 : 0;

    slot_state_t       state;
    logic              valid;
    logic [TW-1:0]     tag_q;
    logic [TW-1:0]     addr_tag;
    logic              hit;
    logic              miss;
    logic              req_q;
    sdram_addr_t       addr_q;
    sdram_addr_t       base_addr;
    logic              wcnt;
    logic              word_idx;
    logic              take;
    logic              last;
    logic [NW*16-1:0]  data_q;

    // Byte clients drop bit 0, it picks the byte later
    assign addr_tag  = addr[AW-1 -: TW];
    assign base_addr = OFFSET + (sdram_addr_t'(addr_tag) << WSH);

    assign hit  = valid && (tag_q == addr_tag);
    assign miss = (state == idle) && cs && !hit;
    assign ok   = cs && hit;

    // dst restarts the word count
    assign word_idx = mem_rsp.dst ? 1'b0 : wcnt;
    assign take     = (state == wait_data) && mem_rsp.rdy;
    assign last     = take && (word_idx == 1'(NW - 1));

    assign mem_req.req  = req_q;
    assign mem_req.addr = addr_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= idle;
            valid <= 1'b0;
            req_q <= 1'b0;
            wcnt  <= 1'b0;
        end else begin
            case (state)
                idle: begin
                    if (miss) begin
                        state <= wait_ack;
                        valid <= 1'b0;
                        req_q <= 1'b1;
                    end
                end
                wait_ack: begin
                    if (mem_rsp.ack) begin
                        state <= wait_data;
                        req_q <= 1'b0;
                    end
                end
                wait_data: begin
                    if (mem_rsp.rdy) begin
                        wcnt <= word_idx + 1'b1;
                    end
                    if (last) begin
                        state <= idle;
                        valid <= 1'b1;
                    end
                end
                default: state <= idle;
            endcase
        end
    end

    // Tag and request address latched on the miss
    always_ff @(posedge clk) begin
        if (miss) begin
            tag_q  <= addr_tag;
            addr_q <= base_addr;
        end
    end

    if (DW == 32) begin : g_wide
        // First word ends up in the lower half
        always_ff @(posedge clk) begin
            if (take) begin
                data_q <= {mem_rsp.data, data_q[31:16]};
            end
        end
        assign dout = data_q;
    end else begin : g_narrow
        always_ff @(posedge clk) begin
            if (take) begin
                data_q <= mem_rsp.data;
            end
        end
        // Even bytes sit in the upper half
        assign dout = addr[0] ? data_q[7:0] : data_q[15:8];
    end

endmodule

`default_nettype wire

// ==== logic/sdram_pkg.sv ====
//////////////////////////////////////////////////
// SDRAM side types shared by the slots, arbiter
// and downloader. Addresses count 16-bit words.
// The byte mask is active low, bit 1 is the
// upper byte.
//////////////////////////////////////////////////
`default_nettype none

package sdram_pkg;

    // One word address into the 4M x 16 SDRAM
    typedef logic [21:0] sdram_addr_t;

    typedef logic [15:0] sdram_word_t;

    // Active low byte enables for writes
    typedef logic [1:0] prog_mask_t;

    // Read request held by a slot until ack
    typedef struct packed {
        logic        req;
        sdram_addr_t addr;
    } sdram_req_t;

    // Response strobes only live for the granted slot
    typedef struct packed {
        logic        ack;
        logic        dst;
        logic        rdy;
        sdram_word_t data;
    } sdram_rsp_t;

endpackage

`default_nettype wire

// ==== logic/slot_arbiter.sv ====
//////////////////////////////////////////////////
// Fixed priority arbiter, main CPU first. Only one
// transfer is in flight, graphics slots read two
// words per grant. No grants while downloading.
//////////////////////////////////////////////////
`default_nettype none

module slot_arbiter (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   downloading,
    input  sdram_pkg::sdram_req_t  slot_req [rom_map_pkg::N_SLOTS],
    input  logic                   sdram_ack,
    input  logic                   data_dst,
    input  logic                   data_rdy,
    input  sdram_pkg::sdram_word_t data_read,
    output sdram_pkg::sdram_rsp_t  slot_rsp [rom_map_pkg::N_SLOTS],
    output logic                   sdram_req,
    output sdram_pkg::sdram_addr_t sdram_addr
);
    import sdram_pkg::*;
    import rom_map_pkg::*;

    localparam int IW = $clog2(N_SLOTS);

    logic               busy;
    logic [IW-1:0]      gnt;
    logic [IW-1:0]      pick;
    logic               any_req;
    logic               start;
    logic               wide;
    logic               wcnt;
    logic               word_idx;
    logic               last_rdy;
    logic [N_SLOTS-1:0] gnt_hot;

    // Scan from the bottom so the lowest index wins
    always_comb begin
        any_req = 1'b0;
        pick    = '0;
        for (int i = N_SLOTS - 1; i >= 0; i--) begin
            if (slot_req[i].req) begin
                any_req = 1'b1;
                pick    = IW'(i);
            end
        end
    end

    assign start = !busy && any_req && !downloading;

    assign wide     = (gnt == IW'(SLOT_SCR)) || (gnt == IW'(SLOT_OBJ));
    assign word_idx = data_dst ? 1'b0 : wcnt;
    assign last_rdy = busy && data_rdy && (!wide || word_idx);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy      <= 1'b0;
            gnt       <= '0;
            sdram_req <= 1'b0;
            wcnt      <= 1'b0;
        end else if (!busy) begin
            if (start) begin
                busy      <= 1'b1;
                gnt       <= pick;
                sdram_req <= 1'b1;
                wcnt      <= 1'b0;
            end
        end else begin
            if (sdram_ack) begin
                sdram_req <= 1'b0;
            end
            if (data_rdy) begin
                wcnt <= word_idx + 1'b1;
            end
            // Back to idle the cycle after the final word
            if (last_rdy) begin
                busy <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            sdram_addr <= slot_req[pick].addr;
        end
    end

    // Strobes go to the granted slot only, data to all
    always_comb begin
        for (int i = 0; i < N_SLOTS; i++) begin
            gnt_hot[i]       = busy && (gnt == IW'(i));
            slot_rsp[i].ack  = gnt_hot[i] && sdram_ack;
            slot_rsp[i].dst  = gnt_hot[i] && data_dst;
            slot_rsp[i].rdy  = gnt_hot[i] && data_rdy;
            slot_rsp[i].data = data_read;
        end
    end

endmodule

`default_nettype wire

// ==== tb.f ====
logic/sdram_pkg.sv
logic/rom_map_pkg.sv
logic/rom_slot.sv
logic/slot_arbiter.sv
logic/rom_dwnld.sv
logic/rom_game_mem.sv
test/sdram_model.sv
test/game_mem_chk.sv
test/tb_game_mem.sv

// ==== test/game_mem_chk.sv ====
//////////////////////////////////////////////////
// Request handshake checks, bound into every
// rom_slot and into rom_dwnld. fail_cnt counts
// failed assertions for the end of run summary.
//////////////////////////////////////////////////
`default_nettype none

module game_mem_chk (
    input logic                   clk,
    input logic                   rst_n,
    input logic                   req,
    input sdram_pkg::sdram_addr_t addr,
    input logic [9:0]             payload,
    input logic                   ack,
    input logic                   quiet
);
    int fail_cnt = 0;

    // Outputs come out of reset low
    a_reset_low: assert property (@(posedge clk) $rose(rst_n) |-> !req && !quiet)
        else begin
            $error("request or ok high right after reset");
            fail_cnt++;
        end

    // Request held until acknowledged
    a_req_hold: assert property (@(posedge clk) disable iff (!rst_n)
        req && !ack |=> req)
        else begin
            $error("request dropped before ack");
            fail_cnt++;
        end

    a_req_stable: assert property (@(posedge clk) disable iff (!rst_n)
        req && !ack |=> $stable(addr) && $stable(payload))
        else begin
            $error("request address or data changed before ack");
            fail_cnt++;
        end

endmodule

bind rom_slot game_mem_chk i_chk (
    .clk     ( clk          ),
    .rst_n   ( rst_n        ),
    .req     ( mem_req.req  ),
    .addr    ( mem_req.addr ),
    .payload ( 10'd0        ),
    .ack     ( mem_rsp.ack  ),
    .quiet   ( ok           )
);

bind rom_dwnld game_mem_chk i_chk (
    .clk     ( clk                    ),
    .rst_n   ( rst_n                  ),
    .req     ( prog_we                ),
    .addr    ( prog_addr              ),
    .payload ( {prog_data, prog_mask} ),
    .ack     ( sdram_ack              ),
    .quiet   ( prog_we                )
);

`default_nettype wire

// ==== test/sdram_model.sv ====
//////////////////////////////////////////////////
// Behavioral 16-bit SDRAM for simulation only.
// Writes take the active low byte mask. Reads
// answer after LAT cycles, graphics regions with
// a two word burst, everything else one word.
//////////////////////////////////////////////////
`default_nettype none

module sdram_model #(
    parameter int LAT = 3
) (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   prog_we,
    input  sdram_pkg::sdram_addr_t prog_addr,
    input  rom_map_pkg::byte_t     prog_data,
    input  sdram_pkg::prog_mask_t  prog_mask,
    input  logic                   sdram_req,
    input  sdram_pkg::sdram_addr_t sdram_addr,
    output logic                   sdram_ack,
    output logic                   data_dst,
    output logic                   data_rdy,
    output sdram_pkg::sdram_word_t data_read
);
    import sdram_pkg::*;
    import rom_map_pkg::*;

    localparam int MEM_WORDS = int'(PROM_START >> 1);

    logic [15:0] mem [MEM_WORDS];
    logic        rd_busy;
    logic        first;
    int          cnt;
    int          words;
    sdram_addr_t rd_addr;

    // Power-up content, unique per address
    initial begin
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem[i] = 16'(i * 32'h9E37) ^ 16'(i >> 16);
        end
    end

    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sdram_ack <= 1'b0;
            data_dst  <= 1'b0;
            data_rdy  <= 1'b0;
            rd_busy   <= 1'b0;
            first     <= 1'b0;
            cnt       <= 0;
            words     <= 0;
        end else begin
            sdram_ack <= 1'b0;
            data_dst  <= 1'b0;
            data_rdy  <= 1'b0;
            if (prog_we && !sdram_ack && !rd_busy) begin
                if (!prog_mask[1]) mem[prog_addr][15:8] <= prog_data;
                if (!prog_mask[0]) mem[prog_addr][7:0] <= prog_data;
                sdram_ack <= 1'b1;
            end else if (sdram_req && !sdram_ack && !rd_busy) begin
                sdram_ack <= 1'b1;
                rd_busy   <= 1'b1;
                rd_addr   <= sdram_addr;
                cnt       <= LAT;
                first     <= 1'b1;
                // Scroll and object tiles come as two words
                words     <= (sdram_addr >= (SCR_START >> 1)) ? 2 : 1;
            end else if (rd_busy) begin
                if (cnt != 0) begin
                    cnt <= cnt - 1;
                end else if (words != 0) begin
                    data_rdy  <= 1'b1;
                    data_dst  <= first;
                    data_read <= mem[rd_addr];
                    first     <= 1'b0;
                    rd_addr   <= rd_addr + 1'b1;
                    words     <= words - 1;
                end else begin
                    rd_busy <= 1'b0;
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== test/tb_game_mem.sv ====
//////////////////////////////////////////////////
// Downloads 256 bytes into each ROM region, then
// reads them back through the four clients.
// Clients index only the downloaded part.
//////////////////////////////////////////////////
`default_nettype none

module tb_game_mem;
    import sdram_pkg::*;
    import rom_map_pkg::*;

    localparam int REGION_BYTES = 256;
    localparam int N_READS      = 64;
    localparam int MEM_WORDS    = int'(PROM_START >> 1);
    localparam int LIMIT = 16 + 4 * REGION_BYTES * 8 + N_SLOTS * N_READS * 64 + 512;

    logic        clk;
    logic        rst_n;
    logic        downloading;
    logic        ioctl_wr;
    logic [24:0] ioctl_addr;
    byte_t       ioctl_dout;
    sdram_addr_t prog_addr;
    byte_t       prog_data;
    prog_mask_t  prog_mask;
    logic        prog_we;
    logic        sdram_ack;
    logic        data_dst;
    logic        data_rdy;
    sdram_word_t data_read;
    logic        sdram_req;
    sdram_addr_t sdram_addr;
    logic        main_cs;
    main_addr_t  main_addr;
    byte_t       main_data;
    logic        main_ok;
    logic        snd_cs;
    snd_addr_t   snd_addr;
    byte_t       snd_data;
    logic        snd_ok;
    logic        scr_cs;
    scr_addr_t   scr_addr;
    gfx_word_t   scr_data;
    logic        scr_ok;
    logic        obj_cs;
    obj_addr_t   obj_addr;
    gfx_word_t   obj_data;
    logic        obj_ok;

    logic [15:0] ref_mem [MEM_WORDS];
    logic [31:0] lfsr = 32'h9766;
    int          cur_addr [N_SLOTS];
    int          errors = 0;
    int          checks = 0;
    int          cycles = 0;
    int          err_mark;

    rom_game_mem i_dut (.*);

    sdram_model #(.LAT(3)) u_sdram (.*);

    initial clk = 1'b0;
    always #4 clk = ~clk;

    always @(posedge clk) begin
        cycles++;
        if (cycles > LIMIT) begin
            $display("Timeout after %0d cycles waiting on the DUT", cycles);
            $display("=== FAIL ===");
            $finish;
        end
    end

    // Galois LFSR, one step per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
        end
        return v;
    endfunction

    // Where the downloader puts a graphics word
    function automatic int place_word(input int w, input logic [21:0] start);
        int s;
        s = w;
        if (start == SCR_START) begin
            s[0] = !w[3];
            s[1] = w[0];
            s[2] = w[1];
            s[3] = w[2];
        end else if (start == OBJ_START) begin
            s[0] = !w[3];
            s[1] = !w[4];
            s[2] = w[0];
            s[3] = w[1];
            s[4] = w[2];
        end
        return s;
    endfunction

    task automatic download_region(input logic [21:0] start);
        byte_t b;
        int    ba;
        int    w;
        for (int i = 0; i < REGION_BYTES; i++) begin
            b  = byte_t'(rand_bits(8));
            ba = int'(start) + i;
            @(posedge clk);
            ioctl_addr <= 25'(ba);
            ioctl_dout <= b;
            ioctl_wr   <= 1'b1;
            @(posedge clk);
            ioctl_wr <= 1'b0;
            do begin
                @(negedge clk);
                assert (!sdram_req) else begin
                    $display("sdram_req raised during the download");
                    errors++;
                end
            end while (prog_we);
            w = place_word(ba >> 1, start);
            if (ba % 2 == 0) ref_mem[w][15:8] = b;
            else ref_mem[w][7:0] = b;
        end
    endtask

    function automatic int rand_addr(input int c);
        return (c < SLOT_SCR) ? int'(rand_bits(8)) : int'(rand_bits(6));
    endfunction

    function automatic logic ok_of(input int c);
        case (c)
            SLOT_MAIN: return main_ok;
            SLOT_SND:  return snd_ok;
            SLOT_SCR:  return scr_ok;
            default:   return obj_ok;
        endcase
    endfunction

    function automatic logic slot_req_of(input int c);
        case (c)
            SLOT_MAIN: return i_dut.u_main.mem_req.req;
            SLOT_SND:  return i_dut.u_snd.mem_req.req;
            SLOT_SCR:  return i_dut.u_scr.mem_req.req;
            default:   return i_dut.u_obj.mem_req.req;
        endcase
    endfunction

    function automatic logic [31:0] expected(input int c, input int a);
        int          base;
        logic [15:0] w;
        case (c)
            SLOT_MAIN: base = a >> 1;
            SLOT_SND:  base = int'(SND_START >> 1) + (a >> 1);
            SLOT_SCR:  base = int'(SCR_START >> 1) + 2 * a;
            default:   base = int'(OBJ_START >> 1) + 2 * a;
        endcase
        if (c >= SLOT_SCR) return {ref_mem[base + 1], ref_mem[base]};
        w = ref_mem[base];
        return (a % 2 == 1) ? {24'd0, w[7:0]} : {24'd0, w[15:8]};
    endfunction

    task automatic drive_client(input int c, input int a);
        cur_addr[c] = a;
        case (c)
            SLOT_MAIN: begin
                main_cs   <= 1'b1;
                main_addr <= main_addr_t'(a);
            end
            SLOT_SND: begin
                snd_cs   <= 1'b1;
                snd_addr <= snd_addr_t'(a);
            end
            SLOT_SCR: begin
                scr_cs   <= 1'b1;
                scr_addr <= scr_addr_t'(a);
            end
            default: begin
                obj_cs   <= 1'b1;
                obj_addr <= obj_addr_t'(a);
            end
        endcase
    endtask

    task automatic check_data(input int c);
        logic [31:0] got;
        logic [31:0] exp;
        string       name;
        case (c)
            SLOT_MAIN: begin
                got  = {24'd0, main_data};
                name = "main_data";
            end
            SLOT_SND: begin
                got  = {24'd0, snd_data};
                name = "snd_data";
            end
            SLOT_SCR: begin
                got  = scr_data;
                name = "scr_data";
            end
            default: begin
                got  = obj_data;
                name = "obj_data";
            end
        endcase
        exp = expected(c, cur_addr[c]);
        checks++;
        assert (got == exp) else begin
            $display("[FAIL] %s addr=%h got=%h exp=%h", name, cur_addr[c], got, exp);
            errors++;
        end
    endtask

    task automatic read_one(input int c, input int a);
        @(posedge clk);
        drive_client(c, a);
        do @(negedge clk); while (!ok_of(c));
        check_data(c);
    endtask

    task automatic report(input int n, input string what);
        $display("test %0d %s: %0d errors", n, what, errors - err_mark);
        err_mark = errors;
    endtask

    initial begin
        int a;
        rst_n       = 1'b0;
        downloading = 1'b0;
        ioctl_wr    = 1'b0;
        ioctl_addr  = '0;
        ioctl_dout  = '0;
        {main_cs, snd_cs, scr_cs, obj_cs} = '0;
        main_addr = '0;
        snd_addr  = '0;
        scr_addr  = '0;
        obj_addr  = '0;
        err_mark  = 0;
        repeat (16) @(posedge clk);
        rst_n <= 1'b1;

        @(negedge clk);
        assert (!sdram_req && !prog_we) else begin
            $display("sdram_req or prog_we high right after reset");
            errors++;
        end
        report(1, "SDRAM request and write low after reset");

        // Main CPU miss pending for the whole download
        @(posedge clk);
        downloading <= 1'b1;
        drive_client(SLOT_MAIN, 0);
        download_region('0);
        download_region(SND_START);
        download_region(SCR_START);
        download_region(OBJ_START);
        @(posedge clk);
        downloading <= 1'b0;
        do @(negedge clk); while (!main_ok);
        check_data(SLOT_MAIN);
        report(2, "no SDRAM read during the download");

        for (int i = 0; i < N_READS; i++) begin
            read_one(SLOT_MAIN, rand_addr(SLOT_MAIN));
            read_one(SLOT_SND, rand_addr(SLOT_SND));
        end
        report(3, "main and sound byte readback");

        for (int i = 0; i < N_READS; i++) begin
            read_one(SLOT_SCR, rand_addr(SLOT_SCR));
            read_one(SLOT_OBJ, rand_addr(SLOT_OBJ));
        end
        report(4, "scroll and object descrambled words");

        // All four miss in the same cycle
        for (int r = 0; r < 8; r++) begin
            @(posedge clk);
            for (int c = 0; c < N_SLOTS; c++) begin
                a = rand_addr(c);
                if (c < SLOT_SCR && (a >> 1) == (cur_addr[c] >> 1)) a = (a + 2) % 256;
                if (c >= SLOT_SCR && a == cur_addr[c]) a = (a + 1) % 64;
                drive_client(c, a);
            end
            do @(negedge clk); while (!(main_ok && snd_ok && scr_ok && obj_ok));
            for (int c = 0; c < N_SLOTS; c++) check_data(c);
        end
        report(5, "four clients missing at once");

        for (int c = 0; c < N_SLOTS; c++) begin
            read_one(c, rand_addr(c));
            @(posedge clk);
            drive_client(c, (c < SLOT_SCR) ? (cur_addr[c] ^ 1) : cur_addr[c]);
            repeat (3) begin
                @(negedge clk);
                assert (ok_of(c) && !slot_req_of(c)) else begin
                    $display("slot %0d refetched a word it already holds", c);
                    errors++;
                end
            end
            check_data(c);
        end
        report(6, "repeated read hits the stored word");

        errors += i_dut.u_main.i_chk.fail_cnt + i_dut.u_snd.i_chk.fail_cnt
                + i_dut.u_scr.i_chk.fail_cnt + i_dut.u_obj.i_chk.fail_cnt
                + i_dut.u_dwnld.i_chk.fail_cnt;
        $display("tests 6, data checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

`default_nettype wire
